// File: verilog.f
isa_pkg.sv
rs_pkg.sv
rs_entry.sv
rs_bank.sv
rs_select.sv
alu_unit.sv
rs_core_top.sv
rs_core_sva.sv
tb_rs_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rs_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_rs_core.sv
// ---------------------------------------------------------------------------
// Random testbench for rs_core_top with a cycle-level model of stations/ALU.
// Inputs change on the falling edge. Each test ends with a one-cycle flush.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_rs_core
    import isa_pkg::*, rs_pkg::*;
();

    localparam int NUM_RS = 4;
    localparam int NUM_TESTS = 6;
    localparam int TEST_LEN [NUM_TESTS] = '{200, 300, 300, 200, 200, 400};
    localparam int TOTAL_LEN = TEST_LEN[0] + TEST_LEN[1] + TEST_LEN[2]
                               + TEST_LEN[3] + TEST_LEN[4] + TEST_LEN[5];
    localparam int CYCLE_LIMIT = 2 * TOTAL_LEN + 100;
    // Test index doubles as the stimulus mode
    localparam int M_INDEP = 0;
    localparam int M_DEP = 1;
    localparam int M_LOAD = 2;
    localparam int M_BRANCH = 3;
    localparam int M_BLOCKED = 4;
    localparam int M_FLUSH = 5;

    logic              clk;
    logic              reset;
    logic              mispredicted;
    logic              stall;
    logic              valid_packet;
    logic [2:0]        rs_dest;
    rs_data_t          d;
    logic [NUM_RS-1:0] busy_bus;
    cdb_packet_t       cdb;

    // Model state
    rs_data_t    m_rs [NUM_RS];
    cdb_packet_t m_cdb;
    logic [15:0] inflight;
    rob_tag_t    next_tag;
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          checks;
    int          errors;
    int          failed_tests;

    rs_core_top #(
        .NUM_RS (NUM_RS)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .mispredicted (mispredicted),
        .stall        (stall),
        .valid_packet (valid_packet),
        .rs_dest      (rs_dest),
        .d            (d),
        .busy_bus     (busy_bus),
        .cdb          (cdb)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Free station in the model, scanned from a random start
    function automatic int free_slot();
        int start;
        int s;
        start = int'(next_rand() % NUM_RS);
        for (int n = 0; n < NUM_RS; n++) begin
            s = (start + n) % NUM_RS;
            if (!m_rs[s].busy) begin
                return s;
            end
        end
        return -1;
    endfunction

    // A tag now on the CDB is captured this edge, so it is no longer usable
    function automatic rob_tag_t pick_dep_tag();
        int start;
        int t;
        start = int'(next_rand() % 32'd15);
        for (int n = 0; n < 15; n++) begin
            t = 1 + (start + n) % 15;
            if (inflight[t] && !(m_cdb.valid && m_cdb.dest_rob_entry == 4'(t))) begin
                return 4'(t);
            end
        end
        return '0;
    endfunction

    // kind 0 is arithmetic, 1 a load, 2 a branch
    function automatic rs_data_t make_packet(int kind, bit dep);
        rs_data_t    p;
        logic [31:0] r;
        r = next_rand();
        p = '0;
        p.busy = 1'b1;
        p.rob_entry = next_tag;
        p.alu_op = alu_op_t'(r[2:0]);
        p.v_j = next_rand();
        // Equal operands now and then so beq and bge see both outcomes
        p.v_k = r[3] ? p.v_j : next_rand();
        p.load = (kind == 1);
        if (kind == 2) begin
            p.branch_type = branch_type_t'(3'(1 + int'(r[5:4])));
        end
        if (dep && r[6]) begin
            p.q_j = pick_dep_tag();
        end
        if (dep && r[7]) begin
            p.q_k = pick_dep_tag();
        end
        return p;
    endfunction

    // Two's complement order, a differing sign bit decides on its own
    function automatic logic signed_less(word_t a, word_t b);
        if (a[XLEN-1] != b[XLEN-1]) begin
            return a[XLEN-1];
        end
        return a < b;
    endfunction

    function automatic word_t alu_result(alu_op_t op, word_t a, word_t b);
        word_t r;
        int    sh;
        sh = int'(b % XLEN);
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a + ~b + 1'b1;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << sh;
            op_srl:  r = a >> sh;
            op_slt:  r = word_t'(signed_less(a, b));
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic branch_outcome(branch_type_t bt, word_t a, word_t b);
        case (bt)
            beq:     return a == b;
            bne:     return a != b;
            blt:     return signed_less(a, b);
            bge:     return !signed_less(a, b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic cdb_packet_t exec_packet(rs_data_t e);
        cdb_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.dest_rob_entry = e.rob_entry;
        if (e.load) begin
            p.result = e.v_j + e.v_k;
            p.load_step1 = 1'b1;
        end else if (e.branch_type != nb) begin
            p.branch_taken = branch_outcome(e.branch_type, e.v_j, e.v_k);
        end else begin
            p.result = alu_result(e.alu_op, e.v_j, e.v_k);
        end
        return p;
    endfunction

    // One rising edge of the model
    task automatic model_update();
        rs_data_t    nxt [NUM_RS];
        cdb_packet_t pkt;
        int          sel;
        logic        issue;
        sel = -1;
        pkt = '0;
        issue = valid_packet && !stall && (int'(rs_dest) < NUM_RS);
        if (reset) begin
            foreach (m_rs[i]) begin
                m_rs[i] = '0;
            end
            m_cdb = '0;
            inflight = '0;
            return;
        end
        for (int i = 0; i < NUM_RS && sel < 0 && !mispredicted; i++) begin
            if (m_rs[i].busy && m_rs[i].q_j == '0 && m_rs[i].q_k == '0
                && m_rs[i].rob_entry != '0) begin
                sel = i;
            end
        end
        if (sel >= 0) begin
            pkt = exec_packet(m_rs[sel]);
        end
        for (int i = 0; i < NUM_RS; i++) begin
            nxt[i] = m_rs[i];
            if (mispredicted || i == sel) begin
                nxt[i] = '0;
            end else if (issue && rs_dest == 3'(i)) begin
                nxt[i] = d;
            end else if (m_cdb.valid && !m_cdb.load_step1) begin
                if (nxt[i].q_j != '0 && nxt[i].q_j == m_cdb.dest_rob_entry) begin
                    nxt[i].q_j = '0;
                    nxt[i].v_j = m_cdb.result;
                end
                if (nxt[i].q_k != '0 && nxt[i].q_k == m_cdb.dest_rob_entry) begin
                    nxt[i].q_k = '0;
                    nxt[i].v_k = m_cdb.result;
                end
            end
        end
        if (m_cdb.valid) begin
            inflight[m_cdb.dest_rob_entry] = 1'b0;
        end
        if (issue) begin
            inflight[d.rob_entry] = 1'b1;
        end
        if (mispredicted) begin
            inflight = '0;
        end
        m_rs = nxt;
        m_cdb = pkt;
    endtask

    task automatic check_outputs();
        logic [NUM_RS-1:0] exp_busy;
        for (int i = 0; i < NUM_RS; i++) begin
            exp_busy[i] = m_rs[i].busy;
        end
        checks += 2;
        assert (busy_bus === exp_busy) else begin
            $display("[ERROR] %0t busy_bus expected %b got %b", $time, exp_busy, busy_bus);
            errors++;
        end
        assert (cdb.valid === m_cdb.valid && (!m_cdb.valid || cdb === m_cdb)) else begin
            $write("[ERROR] %0t cdb expected v%b tag %0d res %h ls %b tk %b",
                   $time, m_cdb.valid, m_cdb.dest_rob_entry, m_cdb.result,
                   m_cdb.load_step1, m_cdb.branch_taken);
            $display(", got v%b tag %0d res %h ls %b tk %b",
                     cdb.valid, cdb.dest_rob_entry, cdb.result,
                     cdb.load_step1, cdb.branch_taken);
            errors++;
        end
    endtask

    task automatic drive_inputs(int mode, bit last);
        logic [31:0] r;
        int          slot;
        int          kind;
        int          thresh;
        r = next_rand();
        slot = free_slot();
        valid_packet = 1'b0;
        stall = 1'b0;
        rs_dest = '0;
        d = '0;
        mispredicted = last || (mode == M_LOAD && r[31:27] == 5'd0)
                       || (mode == M_FLUSH && r[31:29] == 3'd0);
        case (mode)
            M_INDEP:   thresh = 70;
            M_BLOCKED: thresh = 256;
            default:   thresh = 190;
        endcase
        case (mode)
            M_LOAD:   kind = r[8] ? 1 : 0;
            M_BRANCH: kind = 2;
            M_FLUSH:  kind = int'(r[9:8]) % 3;
            default:  kind = 0;
        endcase
        if (slot >= 0 && int'(r[7:0]) < thresh) begin
            d = make_packet(kind, mode == M_DEP || mode == M_LOAD || mode == M_FLUSH);
            valid_packet = 1'b1;
            rs_dest = 3'(slot);
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            // Most writes here are dropped by stall, no valid, or a bad index
            if (mode == M_BLOCKED) begin
                case (r[11:10])
                    2'd1:    stall = 1'b1;
                    2'd2:    valid_packet = 1'b0;
                    2'd3:    rs_dest = 3'(NUM_RS + int'(r[12]));
                    default: ;
                endcase
            end
        end
    endtask

    function automatic string test_name(int t);
        case (t)
            M_INDEP:   return "independent";
            M_DEP:     return "dependent";
            M_LOAD:    return "load_address";
            M_BRANCH:  return "branch";
            M_BLOCKED: return "blocked_write";
            default:   return "random_flush";
        endcase
    endfunction

    task automatic run_test(int t);
        int errors_before;
        errors_before = errors;
        for (int c = 0; c < TEST_LEN[t]; c++) begin
            drive_inputs(t, c == TEST_LEN[t] - 1);
            @(posedge clk);
            model_update();
            @(negedge clk);
            check_outputs();
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("Test %0d %s %s, %0d errors", t + 1, test_name(t),
                 (errors == errors_before) ? "passed" : "failed", errors - errors_before);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mispredicted = 1'b0;
        stall = 1'b0;
        valid_packet = 1'b0;
        rs_dest = '0;
        d = '0;
        rng_state = 32'h9d9ed220;
        next_tag = 4'd1;
        inflight = '0;
        checks = 0;
        errors = 0;
        failed_tests = 0;
        repeat (3) begin
            @(posedge clk);
            model_update();
        end
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: rs_core_sva.sv
// ---------------------------------------------------------------------------
// Assertions on the selector and ALU connections, bound into rs_core_top
// where consumed_bus, exec_valid and the CDB meet one clock.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_core_sva #(
    parameter int NUM_RS = 4
) (
    input logic              clk,
    input logic              reset,
    input logic              mispredicted,
    input logic [NUM_RS-1:0] consumed_bus,
    input logic              exec_valid,
    input logic              cdb_valid
);

    a_one_consumed: assert property (@(posedge clk) disable iff (reset)
        $onehot0(consumed_bus))
        else $error("more than one station consumed in a cycle");

    // Registered ALU, one cycle from dispatch to broadcast
    a_cdb_after_dispatch: assert property (@(posedge clk) disable iff (reset)
        exec_valid |=> cdb_valid)
        else $error("dispatch not followed by a CDB broadcast");

    a_cdb_idle: assert property (@(posedge clk) disable iff (reset)
        !exec_valid |=> !cdb_valid)
        else $error("CDB broadcast without a dispatch");

    a_no_select_on_flush: assert property (@(posedge clk) disable iff (reset)
        mispredicted |-> (consumed_bus == '0 && !exec_valid))
        else $error("station selected while mispredicted is high");

endmodule

bind rs_core_top rs_core_sva #(
    .NUM_RS (NUM_RS)
) u_rs_core_sva (
    .clk          (clk),
    .reset        (reset),
    .mispredicted (mispredicted),
    .consumed_bus (consumed_bus),
    .exec_valid   (exec_valid),
    .cdb_valid    (cdb.valid)
);

// File: rs_core_top.sv
// ---------------------------------------------------------------------------
// Issue-to-execute slice: station bank, selector and one ALU.
// The ALU result is looped back to the stations as the CDB.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_core_top
    import rs_pkg::*;
#(
    parameter int NUM_RS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mispredicted,
    input  logic              stall,
    input  logic              valid_packet,
    input  logic [2:0]        rs_dest,
    input  rs_data_t          d,
    output logic [NUM_RS-1:0] busy_bus,
    output cdb_packet_t       cdb
);

    rs_out_t           rs_out [NUM_RS];
    logic [NUM_RS-1:0] consumed_bus;
    logic              exec_valid;
    rs_out_t           exec_entry;

    rs_bank #(
        .NUM_RS (NUM_RS)
    ) u_rs_bank (
        .clk          (clk),
        .reset        (reset),
        .mispredicted (mispredicted),
        .stall        (stall),
        .valid_packet (valid_packet),
        .rs_dest      (rs_dest),
        .d            (d),
        .cdb          (cdb),
        .consumed_bus (consumed_bus),
        .busy_bus     (busy_bus),
        .rs_out       (rs_out)
    );

    rs_select #(
        .NUM_RS (NUM_RS)
    ) u_rs_select (
        .mispredicted (mispredicted),
        .rs_out       (rs_out),
        .consumed_bus (consumed_bus),
        .exec_valid   (exec_valid),
        .exec_entry   (exec_entry)
    );

    alu_unit u_alu_unit (
        .clk        (clk),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec_entry (exec_entry),
        .cdb        (cdb)
    );

endmodule

// File: alu_unit.sv
// ---------------------------------------------------------------------------
// Single-cycle integer ALU with a registered CDB output, one entry per cycle.
// Loads only produce their address (load_step1), branches only a taken flag.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module alu_unit
    import isa_pkg::*, rs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        exec_valid,
    input  rs_out_t     exec_entry,
    output cdb_packet_t cdb
);

    cdb_packet_t next_pkt;
    cdb_packet_t pkt_q;
    logic        valid_q;

    // Result for the entry dispatched this cycle
    always_comb begin
        next_pkt                = '0;
        next_pkt.valid          = exec_valid;
        next_pkt.dest_rob_entry = exec_entry.rob_entry;
        if (exec_entry.load) begin
            // Address generation, memory access happens elsewhere
            next_pkt.result     = exec_entry.rs1 + exec_entry.rs2;
            next_pkt.load_step1 = 1'b1;
        end else if (exec_entry.branch_type != nb) begin
            next_pkt.branch_taken = branch_eval(exec_entry.branch_type,
                                                exec_entry.rs1, exec_entry.rs2);
        end else begin
            next_pkt.result = alu_eval(exec_entry.alu_op,
                                       exec_entry.rs1, exec_entry.rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exec_valid;
        end
    end

    // Payload only loads on dispatch
    always_ff @(posedge clk) begin
        if (exec_valid) begin
            pkt_q <= next_pkt;
        end
    end

    always_comb begin
        cdb       = pkt_q;
        cdb.valid = valid_q;
    end

endmodule

// File: rs_select.sv
// ---------------------------------------------------------------------------
// Fixed-priority selector, lowest station index wins. Purely combinational.
// Nothing is dispatched while mispredicted is high.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_select
    import rs_pkg::*;
#(
    parameter int NUM_RS = 4
) (
    input  logic              mispredicted,
    input  rs_out_t           rs_out [NUM_RS],
    output logic [NUM_RS-1:0] consumed_bus,
    output logic              exec_valid,
    output rs_out_t           exec_entry
);

    logic [NUM_RS-1:0] ready;

    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            ready[i] = rs_out[i].valid_operands;
        end
    end

    always_comb begin
        consumed_bus = '0;
        exec_valid   = 1'b0;
        exec_entry   = '0;
        if (!mispredicted) begin
            // Walk from the top down so the lowest ready index is kept
            for (int i = NUM_RS - 1; i >= 0; i--) begin
                if (ready[i]) begin
                    consumed_bus    = '0;
                    consumed_bus[i] = 1'b1;
                    exec_valid      = 1'b1;
                    exec_entry      = rs_out[i];
                end
            end
        end
    end

endmodule

// File: rs_bank.sv
// ---------------------------------------------------------------------------
// Bank of NUM_RS stations (NUM_RS at most 8). Issue indices at or above
// NUM_RS write nothing. The issuer must only target free stations.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_bank
    import rs_pkg::*;
#(
    parameter int NUM_RS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mispredicted,
    input  logic              stall,
    input  logic              valid_packet,
    input  logic [2:0]        rs_dest,
    input  rs_data_t          d,
    input  cdb_packet_t       cdb,
    input  logic [NUM_RS-1:0] consumed_bus,
    output logic [NUM_RS-1:0] busy_bus,
    output rs_out_t           rs_out [NUM_RS]
);

    logic              issue_en;
    logic [NUM_RS-1:0] wr_en;
    logic [NUM_RS-1:0] clear;

    assign issue_en = valid_packet && !stall;

    for (genvar i = 0; i < NUM_RS; i++) begin : g_station
        // One-hot write decode of the issue index
        assign wr_en[i] = issue_en && (rs_dest == 3'(i));

        // Flush empties every station, dispatch empties just the chosen one
        assign clear[i] = mispredicted || consumed_bus[i];

        rs_entry u_rs_entry (
            .clk   (clk),
            .reset (reset),
            .clear (clear[i]),
            .wr_en (wr_en[i]),
            .d     (d),
            .cdb   (cdb),
            .busy  (busy_bus[i]),
            .out   (rs_out[i])
        );
    end

endmodule

// File: rs_entry.sv
// ---------------------------------------------------------------------------
// Single reservation station. clear has priority over wr_en, which has
// priority over CDB capture in the same edge.
// Load address broadcasts (load_step1) are never captured.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_entry
    import isa_pkg::*, rs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        wr_en,
    input  rs_data_t    d,
    input  cdb_packet_t cdb,
    output logic        busy,
    output rs_out_t     out
);

    localparam rs_data_t empty_entry = '{
        q_j:         '0,
        q_k:         '0,
        v_j:         '0,
        v_k:         '0,
        load:        1'b0,
        rob_entry:   '0,
        alu_op:      op_add,
        branch_type: nb,
        busy:        1'b0
    };

    rs_data_t q;
    logic     cdb_usable;
    logic     hit_j;
    logic     hit_k;

    // Only real results are forwarded to waiting operands
    assign cdb_usable = cdb.valid && !cdb.load_step1;
    assign hit_j = cdb_usable && (q.q_j != '0) && (cdb.dest_rob_entry == q.q_j);
    assign hit_k = cdb_usable && (q.q_k != '0) && (cdb.dest_rob_entry == q.q_k);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            q <= empty_entry;
        end else if (wr_en) begin
            q <= d;
        end else begin
            if (hit_j) begin
                q.q_j <= '0;
                q.v_j <= cdb.result;
            end
            if (hit_k) begin
                q.q_k <= '0;
                q.v_k <= cdb.result;
            end
        end
    end

    always_comb begin
        busy = q.busy;
        // Ready once both tags resolved and the entry owns a ROB slot
        out.valid_operands = q.busy && (q.q_j == '0) && (q.q_k == '0)
                             && (q.rob_entry != '0);
        out.alu_op      = q.alu_op;
        out.rob_entry   = q.rob_entry;
        out.branch_type = q.branch_type;
        out.rs1         = q.v_j;
        out.rs2         = q.v_k;
        out.load        = q.load;
    end

endmodule

// File: rs_pkg.sv
// ---------------------------------------------------------------------------
// Reservation station, selector view and CDB packet layouts.
// A ROB tag of zero means the operand already holds its value.
// ---------------------------------------------------------------------------
package rs_pkg;

    import isa_pkg::*;

    localparam int ROB_TAG_W = 4;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Contents of one station as written by the issue stage
    typedef struct packed {
        rob_tag_t     q_j;
        rob_tag_t     q_k;
        word_t        v_j;
        word_t        v_k;
        logic         load;
        rob_tag_t     rob_entry;
        alu_op_t      alu_op;
        branch_type_t branch_type;
        logic         busy;
    } rs_data_t;

    // What the selector and the ALU see from a station
    typedef struct packed {
        logic         valid_operands;
        alu_op_t      alu_op;
        rob_tag_t     rob_entry;
        branch_type_t branch_type;
        word_t        rs1;
        word_t        rs2;
        logic         load;
    } rs_out_t;

    // One broadcast on the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t dest_rob_entry;
        word_t    result;
        // Load address only, not a value to capture
        logic     load_step1;
        logic     branch_taken;
    } cdb_packet_t;

endpackage

// File: isa_pkg.sv
// ---------------------------------------------------------------------------
// Integer datapath definitions shared by the ALU and the testbench model.
// Shifts use the low log2(XLEN) bits of the second operand.
// slt, blt and bge compare as signed two's complement.
// ---------------------------------------------------------------------------
package isa_pkg;

    localparam int XLEN = 32;
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_slt
    } alu_op_t;

    // nb marks a non-branch instruction
    typedef enum logic [2:0] {
        nb, beq, bne, blt, bge
    } branch_type_t;

    function automatic word_t alu_eval(alu_op_t op, word_t a, word_t b);
        word_t r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << b[SHAMT_W-1:0];
            op_srl:  r = a >> b[SHAMT_W-1:0];
            op_slt:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic branch_eval(branch_type_t bt, word_t a, word_t b);
        logic taken;
        case (bt)
            beq:     taken = (a == b);
            bne:     taken = (a != b);
            blt:     taken = ($signed(a) < $signed(b));
            bge:     taken = ($signed(a) >= $signed(b));
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

endpackage
